// ==== design/core_pkg.sv ====
package core_pkg;

    localparam int WORD_LEN     = 32;
    localparam int REG_COUNT    = 32;
    localparam int REG_ADDR_LEN = 5;
    localparam int INST_BYTES   = 4;

    typedef logic [WORD_LEN-1:0]     word_t;
    typedef logic [REG_ADDR_LEN-1:0] reg_addr_t;

    localparam word_t     EXIT_PC = 32'h0000_0044; // fetch here means halt
    localparam reg_addr_t GP_REG  = 5'd3;

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW_SW   = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_JALR, ALU_NONE
    } alu_fn_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_fn_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;
    typedef enum logic {OP2_RS2, OP2_IMM} op2_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

    // one instruction word, one view per encoding format
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef struct packed {
        alu_fn_e  alu_fn;
        br_fn_e   br_fn;
        op1_sel_e op1_sel;
        op2_sel_e op2_sel;
        logic     mem_wen;
        logic     rf_wen;
        wb_sel_e  wb_sel;
        logic     jump;
    } ctrl_t;

    // no write, no store, no branch
    localparam ctrl_t CTRL_NOP = '{alu_fn: ALU_NONE, br_fn: BR_NONE, op1_sel: OP1_ZERO,
                                   op2_sel: OP2_RS2, mem_wen: 1'b0, rf_wen: 1'b0,
                                   wb_sel: WB_ALU, jump: 1'b0};

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        word_t     imm;       // operand 2 immediate
        word_t     br_offset;
    } dec_t;

    typedef struct packed {
        word_t alu_out;
        logic  br_taken;
    } ex_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  wen;
    } dmem_req_t;

endpackage

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  dec_t  dec_i,
    input  ex_t   ex_i,
    output word_t pc_o,
    output logic  exit_o
);

    word_t pc_q;
    word_t pc_next;

    // branch beats jump beats sequential
    always_comb begin
        if (ex_i.br_taken) begin
            pc_next = pc_q + dec_i.br_offset;
        end else if (dec_i.ctrl.jump) begin
            pc_next = ex_i.alu_out;
        end else begin
            pc_next = pc_q + INST_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (!exit_o) begin // frozen once halted
            pc_q <= pc_next;
        end
    end

    assign exit_o = (pc_q == EXIT_PC);
    assign pc_o   = pc_q;

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import core_pkg::*;
(
    input  inst_u inst_i,
    output dec_t  dec_o
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_j;
    word_t imm_u;
    logic  f7_base;
    logic  f7_alt;

    // funct3 to alu op, alt picks sub / sra
    function automatic alu_fn_e alu_of(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SR:      return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign imm_i = {{20{inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
    assign imm_s = {{20{inst_i.s_fmt.imm_hi[6]}}, inst_i.s_fmt.imm_hi, inst_i.s_fmt.imm_lo};
    assign imm_j = {{12{inst_i.j_fmt.imm_20}}, inst_i.j_fmt.imm_19_12,
                    inst_i.j_fmt.imm_11, inst_i.j_fmt.imm_10_1, 1'b0};
    assign imm_u = {inst_i.u_fmt.imm, 12'b0};

    assign f7_base = (inst_i.r_fmt.funct7 == F7_BASE);
    assign f7_alt  = (inst_i.r_fmt.funct7 == F7_ALT);

    always_comb begin
        dec_o.ctrl      = CTRL_NOP;
        dec_o.rs1_addr  = inst_i.r_fmt.rs1;
        dec_o.rs2_addr  = inst_i.r_fmt.rs2;
        dec_o.rd_addr   = inst_i.r_fmt.rd;
        dec_o.imm       = imm_i;
        dec_o.br_offset = {{20{inst_i.b_fmt.imm_12}}, inst_i.b_fmt.imm_11,
                           inst_i.b_fmt.imm_10_5, inst_i.b_fmt.imm_4_1, 1'b0};

        case (inst_i.r_fmt.opcode)
            OPC_LOAD: if (inst_i.i_fmt.funct3 == F3_LW_SW) begin
                dec_o.ctrl.alu_fn  = ALU_ADD;
                dec_o.ctrl.op1_sel = OP1_RS1;
                dec_o.ctrl.op2_sel = OP2_IMM;
                dec_o.ctrl.rf_wen  = 1'b1;
                dec_o.ctrl.wb_sel  = WB_MEM;
            end
            OPC_STORE: if (inst_i.s_fmt.funct3 == F3_LW_SW) begin
                dec_o.ctrl.alu_fn  = ALU_ADD;
                dec_o.ctrl.op1_sel = OP1_RS1;
                dec_o.ctrl.op2_sel = OP2_IMM;
                dec_o.ctrl.mem_wen = 1'b1;
                dec_o.imm          = imm_s;
            end
            OPC_OP: begin
                // alt funct7 is only legal for sub and sra
                if (f7_base || (f7_alt && (inst_i.r_fmt.funct3 == F3_ADD_SUB ||
                                           inst_i.r_fmt.funct3 == F3_SR))) begin
                    dec_o.ctrl.alu_fn  = alu_of(inst_i.r_fmt.funct3, f7_alt);
                    dec_o.ctrl.op1_sel = OP1_RS1;
                    dec_o.ctrl.op2_sel = OP2_RS2;
                    dec_o.ctrl.rf_wen  = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                // funct7 only matters for the shift amounts
                if ((inst_i.i_fmt.funct3 != F3_SLL && inst_i.i_fmt.funct3 != F3_SR) ||
                    f7_base || (f7_alt && inst_i.i_fmt.funct3 == F3_SR)) begin
                    dec_o.ctrl.alu_fn  = alu_of(inst_i.i_fmt.funct3,
                                                f7_alt && inst_i.i_fmt.funct3 == F3_SR);
                    dec_o.ctrl.op1_sel = OP1_RS1;
                    dec_o.ctrl.op2_sel = OP2_IMM;
                    dec_o.ctrl.rf_wen  = 1'b1;
                end
            end
            OPC_BRANCH: begin
                dec_o.ctrl.op1_sel = OP1_RS1;
                dec_o.ctrl.op2_sel = OP2_RS2;
                case (inst_i.b_fmt.funct3)
                    F3_BEQ:  dec_o.ctrl.br_fn = BR_EQ;
                    F3_BNE:  dec_o.ctrl.br_fn = BR_NE;
                    F3_BLT:  dec_o.ctrl.br_fn = BR_LT;
                    F3_BGE:  dec_o.ctrl.br_fn = BR_GE;
                    F3_BLTU: dec_o.ctrl.br_fn = BR_LTU;
                    F3_BGEU: dec_o.ctrl.br_fn = BR_GEU;
                    default: dec_o.ctrl.br_fn = BR_NONE;
                endcase
            end
            OPC_JAL: begin
                dec_o.ctrl.alu_fn  = ALU_ADD;
                dec_o.ctrl.op1_sel = OP1_PC;
                dec_o.ctrl.op2_sel = OP2_IMM;
                dec_o.ctrl.rf_wen  = 1'b1;
                dec_o.ctrl.wb_sel  = WB_PC4;
                dec_o.ctrl.jump    = 1'b1;
                dec_o.imm          = imm_j;
            end
            OPC_JALR: if (inst_i.i_fmt.funct3 == 3'b000) begin
                dec_o.ctrl.alu_fn  = ALU_JALR;
                dec_o.ctrl.op1_sel = OP1_RS1;
                dec_o.ctrl.op2_sel = OP2_IMM;
                dec_o.ctrl.rf_wen  = 1'b1;
                dec_o.ctrl.wb_sel  = WB_PC4;
                dec_o.ctrl.jump    = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                dec_o.ctrl.alu_fn  = ALU_ADD;
                dec_o.ctrl.op1_sel = (inst_i.u_fmt.opcode == OPC_LUI) ? OP1_ZERO : OP1_PC;
                dec_o.ctrl.op2_sel = OP2_IMM;
                dec_o.ctrl.rf_wen  = 1'b1;
                dec_o.imm          = imm_u;
            end
            default: dec_o.ctrl = CTRL_NOP; // unknown word
        endcase
    end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
    import core_pkg::*;
(
    input  dec_t  dec_i,
    input  word_t pc_i,
    input  word_t rs1_data_i,
    input  word_t rs2_data_i,
    output ex_t   ex_o
);

    word_t      op1;
    word_t      op2;
    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    always_comb begin
        case (dec_i.ctrl.op1_sel)
            OP1_RS1: op1 = rs1_data_i;
            OP1_PC:  op1 = pc_i;
            default: op1 = '0; // lui
        endcase
    end

    assign op2   = (dec_i.ctrl.op2_sel == OP2_IMM) ? dec_i.imm : rs2_data_i;
    assign shamt = op2[4:0];
    assign lt_s  = $signed(op1) < $signed(op2);
    assign lt_u  = op1 < op2;

    always_comb begin
        case (dec_i.ctrl.alu_fn)
            ALU_ADD:  ex_o.alu_out = op1 + op2;
            ALU_SUB:  ex_o.alu_out = op1 - op2;
            ALU_AND:  ex_o.alu_out = op1 & op2;
            ALU_OR:   ex_o.alu_out = op1 | op2;
            ALU_XOR:  ex_o.alu_out = op1 ^ op2;
            ALU_SLL:  ex_o.alu_out = op1 << shamt;
            ALU_SRL:  ex_o.alu_out = op1 >> shamt;
            ALU_SRA:  ex_o.alu_out = word_t'($signed(op1) >>> shamt);
            ALU_SLT:  ex_o.alu_out = {31'b0, lt_s};
            ALU_SLTU: ex_o.alu_out = {31'b0, lt_u};
            ALU_JALR: ex_o.alu_out = (op1 + op2) & ~32'd1; // target with bit 0 cleared
            default:  ex_o.alu_out = '0;
        endcase
    end

    always_comb begin
        case (dec_i.ctrl.br_fn)
            BR_EQ:   ex_o.br_taken = (op1 == op2);
            BR_NE:   ex_o.br_taken = (op1 != op2);
            BR_LT:   ex_o.br_taken = lt_s;
            BR_GE:   ex_o.br_taken = !lt_s;
            BR_LTU:  ex_o.br_taken = lt_u;
            BR_GEU:  ex_o.br_taken = !lt_u;
            default: ex_o.br_taken = 1'b0;
        endcase
    end

endmodule

// ==== design/writeback_regfile.sv ====
`timescale 1ns/1ps

module writeback_regfile
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  dec_t  dec_i,
    input  word_t pc_i,
    input  word_t alu_out_i,
    input  word_t mem_rdata_i,
    output word_t rs1_data_o,
    output word_t rs2_data_o,
    output word_t gp_o,
    input  logic  stall_i
);

    word_t regs [REG_COUNT];
    word_t wb_data;

    always_comb begin
        case (dec_i.ctrl.wb_sel)
            WB_MEM:  wb_data = mem_rdata_i;
            WB_PC4:  wb_data = pc_i + INST_BYTES; // link address
            default: wb_data = alu_out_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (dec_i.ctrl.rf_wen && dec_i.rd_addr != '0 && !stall_i) begin
            regs[dec_i.rd_addr] <= wb_data;
        end
    end

    // x0 reads as zero
    assign rs1_data_o = (dec_i.rs1_addr == '0) ? '0 : regs[dec_i.rs1_addr];
    assign rs2_data_o = (dec_i.rs2_addr == '0) ? '0 : regs[dec_i.rs2_addr];
    assign gp_o       = regs[GP_REG];

endmodule

// ==== design/core_top.sv ====
`timescale 1ns/1ps

module core_top
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    output word_t     imem_addr_o,
    input  word_t     imem_data_i,
    output dmem_req_t dmem_req_o,
    input  word_t     dmem_rdata_i,
    output word_t     gp_o,
    output logic      exit_o
);

    word_t pc;
    dec_t  dec;
    ex_t   ex;
    word_t rs1_data;
    word_t rs2_data;
    logic  exit;

    fetch_stage u_fetch (
        .clk    (clk),
        .rst_n  (rst_n),
        .dec_i  (dec),
        .ex_i   (ex),
        .pc_o   (pc),
        .exit_o (exit)
    );

    decode_stage u_decode (
        .inst_i (imem_data_i),
        .dec_o  (dec)
    );

    writeback_regfile u_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec_i       (dec),
        .pc_i        (pc),
        .alu_out_i   (ex.alu_out),
        .mem_rdata_i (dmem_rdata_i),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .gp_o        (gp_o),
        .stall_i     (exit)
    );

    execute_stage u_execute (
        .dec_i      (dec),
        .pc_i       (pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .ex_o       (ex)
    );

    assign imem_addr_o = pc;
    assign exit_o      = exit;
    // store is dropped while halted
    assign dmem_req_o  = '{addr: ex.alu_out, wdata: rs2_data, wen: dec.ctrl.mem_wen && !exit};

endmodule

// ==== test/core_tb.sv ====
`timescale 1ns/1ps

module core_tb
    import core_pkg::*;
();

    localparam int N_PROGS  = 12;
    localparam int PROG_LEN = 17;  // words below the exit address
    localparam int WAIT_MAX = 500;
    localparam int HOLD_CYC = 5;

    logic      clk;
    logic      rst_n;
    word_t     imem_addr;
    word_t     imem_data;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    word_t     gp;
    logic      exit_flag;

    word_t imem [32];
    word_t dmem [256];
    word_t m_regs [REG_COUNT];
    word_t m_mem [256];
    word_t m_pc;
    int    seed = 32'h6707_0f5e;
    int    n_mismatch = 0;
    int    n_timeout = 0;

    core_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_req_o   (dmem_req),
        .dmem_rdata_i (dmem_rdata),
        .gp_o         (gp),
        .exit_o       (exit_flag)
    );

    // memories read combinationally
    assign imem_data  = imem[imem_addr[6:2]];
    assign dmem_rdata = dmem[dmem_req.addr[9:2]];

    always @(posedge clk) begin
        if (rst_n && dmem_req.wen) begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_pc(input word_t got, input word_t exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t: imem_addr_o %h, expected pc %h", $time, got, exp);
        end
    endtask

    task automatic check_gp(input word_t got, input word_t exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t: gp_o %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_exit(input logic got, input logic exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t: exit_o %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_store(input dmem_req_t got, input dmem_req_t exp);
        if (got.wen !== exp.wen ||
            (exp.wen && (got.addr !== exp.addr || got.wdata !== exp.wdata))) begin
            n_mismatch++;
            $display("Mismatch at %0t: store wen %b addr %h data %h, expected %b %h %h",
                     $time, got.wen, got.addr, got.wdata, exp.wen, exp.addr, exp.wdata);
        end
    endtask

    function automatic int unsigned next_rand();
        return $unsigned($random(seed));
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << b[4:0];
            F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     return a ^ b;
            F3_SR:      return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    function automatic logic taken_ref(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // retires one word on the model state, returns the store it issues
    function automatic dmem_req_t ref_step(input inst_u w);
        dmem_req_t  req;
        word_t      rs1;
        word_t      rs2;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_j;
        word_t      addr;
        word_t      res;
        word_t      next_pc;
        logic [2:0] f3;
        logic       wr;
        req = '0;
        if (m_pc == EXIT_PC) begin
            return req; // halted
        end
        rs1     = m_regs[w.r_fmt.rs1];
        rs2     = m_regs[w.r_fmt.rs2];
        f3      = w.r_fmt.funct3;
        imm_i   = {{20{w.i_fmt.imm[11]}}, w.i_fmt.imm};
        imm_s   = {{20{w.s_fmt.imm_hi[6]}}, w.s_fmt.imm_hi, w.s_fmt.imm_lo};
        imm_b   = {{20{w.b_fmt.imm_12}}, w.b_fmt.imm_11, w.b_fmt.imm_10_5,
                   w.b_fmt.imm_4_1, 1'b0};
        imm_j   = {{12{w.j_fmt.imm_20}}, w.j_fmt.imm_19_12, w.j_fmt.imm_11,
                   w.j_fmt.imm_10_1, 1'b0};
        res     = '0;
        wr      = 1'b1;
        next_pc = m_pc + 32'd4;
        case (w.r_fmt.opcode)
            OPC_OP:     res = alu_ref(f3, w.r_fmt.funct7[5], rs1, rs2);
            OPC_OP_IMM: res = alu_ref(f3, f3 == F3_SR && w.i_fmt.imm[10], rs1, imm_i);
            OPC_LUI:    res = {w.u_fmt.imm, 12'b0};
            OPC_AUIPC:  res = m_pc + {w.u_fmt.imm, 12'b0};
            OPC_LOAD: begin
                addr = rs1 + imm_i;
                res  = m_mem[addr[9:2]];
            end
            OPC_STORE: begin
                wr   = 1'b0;
                addr = rs1 + imm_s;
                req  = '{addr: addr, wdata: rs2, wen: 1'b1};
                m_mem[addr[9:2]] = rs2;
            end
            OPC_BRANCH: begin
                wr = 1'b0;
                if (taken_ref(f3, rs1, rs2)) begin
                    next_pc = m_pc + imm_b;
                end
            end
            OPC_JAL: begin
                res     = m_pc + 32'd4;
                next_pc = m_pc + imm_j;
            end
            OPC_JALR: begin
                res     = m_pc + 32'd4;
                next_pc = (rs1 + imm_i) & 32'hffff_fffe;
            end
            default: wr = 1'b0;
        endcase
        if (wr && w.r_fmt.rd != 5'd0) begin
            m_regs[w.r_fmt.rd] = res;
        end
        m_pc = next_pc;
        return req;
    endfunction

    // random word at index i; control flow only goes forward, at most to EXIT_PC
    function automatic word_t gen_word(input int i);
        int unsigned kind;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic        alt;
        kind = next_rand() % 11;
        f3   = 3'(next_rand());
        imm  = 12'(next_rand());
        alt  = 1'(next_rand());
        rd   = (next_rand() % 2 == 0) ? GP_REG : reg_addr_t'(next_rand() % 8);
        rs1  = reg_addr_t'(next_rand() % 8);
        rs2  = reg_addr_t'(next_rand() % 8);
        boff = 13'((1 + next_rand() % (PROG_LEN - i)) * 4);
        joff = 21'(boff);
        case (kind)
            0: begin
                alt = alt && (f3 == F3_ADD_SUB || f3 == F3_SR);
                return {alt ? F7_ALT : F7_BASE, rs2, rs1, f3, rd, OPC_OP};
            end
            1: begin
                if (f3 == F3_SLL || f3 == F3_SR) begin
                    imm[11:5] = (alt && f3 == F3_SR) ? F7_ALT : F7_BASE;
                end
                return {imm, rs1, f3, rd, OPC_OP_IMM};
            end
            2:    return {imm, imm[7:0], rd, OPC_LUI};
            3:    return {imm, imm[7:0], rd, OPC_AUIPC};
            4, 5: return {12'h100 + 12'(4 * (next_rand() % 16)), 5'd0, F3_LW_SW, rd, OPC_LOAD};
            6: begin
                imm = 12'h100 + 12'(4 * (next_rand() % 16));
                return {imm[11:5], rs2, 5'd0, F3_LW_SW, imm[4:0], OPC_STORE};
            end
            7, 8: begin
                if (f3 == 3'd2 || f3 == 3'd3) begin
                    f3 = f3 + 3'd4; // no such branch codes
                end
                return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OPC_BRANCH};
            end
            9: return {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
            default: begin
                imm = (12'(i * 4) + 12'(boff)) | {11'b0, alt}; // odd target sometimes
                return {imm, 5'd0, 3'b000, rd, OPC_JALR};
            end
        endcase
    endfunction

    task automatic load_program(input int p);
        word_t salt;
        salt = $random(seed);
        for (int i = 0; i < 32; i++) begin
            imem[i] = {12'(i * 4), 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM};
        end
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            imem[i] = gen_word(i);
        end
        imem[PROG_LEN - 1] = {1'b0, 10'd2, 1'b0, 8'd0, 5'd1, OPC_JAL}; // jal x1 to exit
        if (p % 2 == 0) begin
            imem[PROG_LEN] = {7'h08, GP_REG, 5'd0, F3_LW_SW, 5'd0, OPC_STORE}; // must not store
        end else begin
            imem[PROG_LEN] = {12'd1, GP_REG, F3_ADD_SUB, GP_REG, OPC_OP_IMM}; // must not bump x3
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i]  = salt ^ (i * 32'h0100_4001);
            m_mem[i] = dmem[i];
        end
    endtask

    task automatic reset_model();
        m_pc = '0;
        for (int i = 0; i < REG_COUNT; i++) begin
            m_regs[i] = '0;
        end
    endtask

    // compare the DUT with the model, then retire the same word on the model
    always @(posedge clk) begin
        dmem_req_t exp_req;
        #2;
        if (rst_n) begin
            check_pc(imem_addr, m_pc);
            check_gp(gp, m_regs[GP_REG]);
            check_exit(exit_flag, m_pc == EXIT_PC);
            exp_req = ref_step(inst_u'(imem[m_pc[6:2]]));
            check_store(dmem_req, exp_req);
        end
    end

    initial begin
        int waited;
        rst_n = 1'b0;
        for (int p = 0; p < N_PROGS && n_timeout == 0; p++) begin
            @(posedge clk);
            #1;
            rst_n = 1'b0;
            load_program(p);
            repeat (3) @(posedge clk);
            #1;
            reset_model();
            rst_n  = 1'b1;
            waited = 0;
            while (exit_flag !== 1'b1 && waited < WAIT_MAX) begin
                @(posedge clk);
                #3;
                waited++;
            end
            if (exit_flag !== 1'b1) begin
                n_timeout++;
                $display("Core never halted within %0d cycles in program %0d", WAIT_MAX, p);
            end else begin
                repeat (HOLD_CYC) begin // pc, gp and store must stay frozen
                    @(posedge clk);
                    #3;
                end
            end
        end
        $display("Errors: %0d mismatches, %0d timeouts", n_mismatch, n_timeout);
        if (n_mismatch == 0 && n_timeout == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
design/core_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_regfile.sv
design/core_top.sv
test/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - design/core_pkg.sv
  - design/fetch_stage.sv
  - design/decode_stage.sv
  - design/execute_stage.sv
  - design/writeback_regfile.sv
  - design/core_top.sv
  - target: test
    files:
      - test/core_tb.sv
